// File: design/cnn_params.svh
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// word geometry
`define WORD_BITS     512
`define LANES         64
`define BIN_BITS      128
// 32-bit host lanes per word, as an address field
`define WLANE_BITS    4

// buffers
`define BUF_DEPTH     64
`define BUF_ADR_BITS  6

// axi4-lite register map
`define AXI_ADR_BITS  14
`define REG_CTRL      14'h000
`define REG_CFG       14'h004
`define REG_STATUS    14'h008
`define REG_RESULT    14'h00C
`define WGT_BASE      14'h1000
`define ACT_BASE      14'h2000

`endif

// File: design/cnn_pkg.sv
`include "cnn_params.svh"

package cnn_pkg;

  // one signed lane value
  typedef logic signed [7:0] sbyte_t;

  // 64 lanes side by side, lane 0 in the low byte
  typedef sbyte_t [`LANES-1:0] lane_vec_t;

  // activation word is plain signed lanes
  typedef lane_vec_t act_word_t;

  // binary view, only the low bits carry weights
  typedef struct packed {
    logic [`WORD_BITS-`BIN_BITS-1:0] unused;
    logic [`BIN_BITS-1:0]            bits;
  } bin_view_t;

  // same weight word, decoded per mode
  typedef union packed {
    lane_vec_t i8;
    bin_view_t bin;
  } weight_word_u;

  // word mode
  typedef enum logic {
    MODE_INT8 = 1'b0,
    MODE_BIN2 = 1'b1
  } wmode_e;

  // tile sum
  typedef logic signed [31:0] acc_t;

endpackage

// File: design/tile_stage_if.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

// buffer read port, data one cycle after en
interface buf_rd_if
  import cnn_pkg::*;
();
  logic                     en;
  logic [`BUF_ADR_BITS-1:0] adr;
  weight_word_u             wgt;
  act_word_t                act;

  modport master (output en, adr, input wgt, act);
  modport slave  (input en, adr, output wgt, act);
endinterface

// lane vector into the mac pipe
interface vec_if
  import cnn_pkg::*;
();
  logic      valid;
  logic      last;
  wmode_e    mode;
  lane_vec_t wvec;
  act_word_t avec;

  modport source (output valid, last, mode, wvec, avec);
  modport sink   (input valid, last, mode, wvec, avec);
endinterface

// File: design/axil_tile_ctrl.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module axil_tile_ctrl
  import cnn_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  // axi4-lite slave
  input  logic [`AXI_ADR_BITS-1:0]  awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [31:0]               wdata,
  input  logic [3:0]                wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`AXI_ADR_BITS-1:0]  araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [31:0]               rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  // buffer write lanes
  output logic                      we_wgt,
  output logic                      we_act,
  output logic [`BUF_ADR_BITS-1:0]  wadr,
  output logic [`WLANE_BITS-1:0]    lane,
  output logic [31:0]               wbus,
  // run control
  output logic                      start,
  output wmode_e                    mode,
  output logic [`BUF_ADR_BITS:0]    tile_len,
  input  logic                      busy,
  input  acc_t                      result,
  input  logic                      result_valid
);

  // word address + lane + byte offset sit below the region bits
  localparam int RGN_LSB = `BUF_ADR_BITS + `WLANE_BITS + 2;
  localparam logic [`AXI_ADR_BITS-1:0] WGT_A = `WGT_BASE;
  localparam logic [`AXI_ADR_BITS-1:0] ACT_A = `ACT_BASE;

  logic        wr_go;
  logic        wr_hs;
  logic        rd_hs;
  logic        done_q;
  acc_t        result_q;
  logic [31:0] rd_mux;

  //////////////////////////////////////////////////////////////////////
  // write channel

  // both valids, nothing outstanding
  assign wr_go = awvalid && wvalid && !awready && !bvalid;
  // ready pulse is the handshake cycle
  assign wr_hs = awready;
  assign bresp = 2'b00;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end
    else
    begin
      awready <= wr_go;
      wready  <= wr_go;
      if (wr_hs)
      begin
        bvalid <= 1'b1;
      end
      else if (bready)
      begin
        bvalid <= 1'b0;
      end
    end
  end

  // buffer lane write straight from the accepted beat
  assign we_wgt = wr_hs && (awaddr[`AXI_ADR_BITS-1:RGN_LSB] == WGT_A[`AXI_ADR_BITS-1:RGN_LSB]);
  assign we_act = wr_hs && (awaddr[`AXI_ADR_BITS-1:RGN_LSB] == ACT_A[`AXI_ADR_BITS-1:RGN_LSB]);
  assign wadr   = awaddr[RGN_LSB-1 -: `BUF_ADR_BITS];
  assign lane   = awaddr[`WLANE_BITS+1:2];
  assign wbus   = wdata;

  //////////////////////////////////////////////////////////////////////
  // register file

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      start    <= 1'b0;
      mode     <= MODE_INT8;
      tile_len <= '0;
      done_q   <= 1'b0;
    end
    else
    begin
      start <= 1'b0;
      // start pulse, dropped while a tile runs
      if (wr_hs && awaddr == `REG_CTRL && wstrb[0] && wdata[0] && !busy && !start)
      begin
        start <= 1'b1;
      end
      if (wr_hs && awaddr == `REG_CFG)
      begin
        if (wstrb[0])
        begin
          mode <= wmode_e'(wdata[0]);
        end
        if (wstrb[2])
        begin
          tile_len <= wdata[16 +: `BUF_ADR_BITS+1];
        end
      end
      // done is sticky until the next start
      if (start)
      begin
        done_q <= 1'b0;
      end
      else if (result_valid)
      begin
        done_q <= 1'b1;
      end
    end
  end

  // result capture
  always_ff @(posedge clk)
  begin
    if (result_valid)
    begin
      result_q <= result;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read channel

  always_comb
  begin
    case (araddr)
      `REG_CFG:    rd_mux = {9'b0, tile_len, 15'b0, mode};
      `REG_STATUS: rd_mux = {30'b0, busy, done_q};
      `REG_RESULT: rd_mux = result_q;
      // ctrl is write only, buffers not readable
      default:     rd_mux = '0;
    endcase
  end

  assign rd_hs = arready;
  assign rresp = 2'b00;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_hs)
      begin
        rvalid <= 1'b1;
      end
      else if (rready)
      begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_hs)
    begin
      rdata <= rd_mux;
    end
  end

  // mac result only comes back inside a run
  a_result_in_run: assert property (@(posedge clk) disable iff (reset)
    result_valid |-> busy);

endmodule

// File: design/tile_buffer.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module tile_buffer
(
  input  logic                     clk,
  input  logic                     we_wgt,
  input  logic                     we_act,
  input  logic [`BUF_ADR_BITS-1:0] wadr,
  input  logic [`WLANE_BITS-1:0]   lane,
  input  logic [31:0]              wbus,
  buf_rd_if.slave                  rd
);

  // weight and activation words, same geometry
  logic [`WORD_BITS-1:0] wgt_mem [`BUF_DEPTH];
  logic [`WORD_BITS-1:0] act_mem [`BUF_DEPTH];

  // host side, one 32-bit lane per write
  always_ff @(posedge clk)
  begin
    if (we_wgt)
    begin
      wgt_mem[wadr][lane*32 +: 32] <= wbus;
    end
    if (we_act)
    begin
      act_mem[wadr][lane*32 +: 32] <= wbus;
    end
  end

  // engine side, full word pair per cycle
  // data lands the cycle after en
  always_ff @(posedge clk)
  begin
    if (rd.en)
    begin
      rd.wgt <= wgt_mem[rd.adr];
      rd.act <= act_mem[rd.adr];
    end
  end

endmodule

// File: design/tile_sequencer.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module tile_sequencer
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic [`BUF_ADR_BITS:0]  tile_len,
  input  logic                    result_valid,
  output logic                    re_fm_en,
  output logic                    re_fm_end,
  output logic                    busy
);

  logic [`BUF_ADR_BITS:0] len_q;
  logic [`BUF_ADR_BITS:0] cnt_q;

  // window is tile_len+1 cycles, end on the final one
  assign re_fm_end = re_fm_en && (cnt_q == len_q);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      re_fm_en <= 1'b0;
      busy     <= 1'b0;
      cnt_q    <= '0;
      len_q    <= '0;
    end
    else if (start)
    begin
      re_fm_en <= 1'b1;
      busy     <= 1'b1;
      cnt_q    <= '0;
      len_q    <= tile_len;
    end
    else
    begin
      if (re_fm_end)
      begin
        re_fm_en <= 1'b0;
      end
      else if (re_fm_en)
      begin
        cnt_q <= cnt_q + 1'b1;
      end
      // busy spans the mac drain too
      if (result_valid)
      begin
        busy <= 1'b0;
      end
    end
  end

  // an empty tile would never produce a result
  a_len_nonzero: assert property (@(posedge clk) disable iff (reset)
    start |-> tile_len != '0);

endmodule

// File: design/cv_weights_handler.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module cv_weights_handler
  import cnn_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  wmode_e   mode,
  input  logic     re_fm_en,
  input  logic     re_fm_end,
  buf_rd_if.master rd,
  vec_if.source    vec
);

  logic [`BUF_ADR_BITS-1:0] adr_cnt;
  logic                     valid_q;
  wmode_e                   mode_q;
  lane_vec_t                wunpack;

  //////////////////////////////////////////////////////////////////////
  // read side

  // end cycle carries no read, only flushes the last vector
  assign rd.en  = re_fm_en && !re_fm_end;
  assign rd.adr = adr_cnt;

  // linear address, back to 0 for the next tile
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      adr_cnt <= '0;
    end
    else if (re_fm_end)
    begin
      adr_cnt <= '0;
    end
    else if (rd.en)
    begin
      adr_cnt <= adr_cnt + 1'b1;
    end
  end

  // data valid one cycle behind the read
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q <= 1'b0;
      mode_q  <= MODE_INT8;
    end
    else
    begin
      valid_q <= rd.en;
      if (rd.en)
      begin
        mode_q <= mode;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // unpack

  // int8: byte per lane
  // bin2: bit pair 2i+1:2i, zero extended
  genvar i;
  generate
    for (i = 0; i < `LANES; i = i + 1)
    begin : g_lane
      assign wunpack[i] = (mode_q == MODE_BIN2) ? {6'b0, rd.wgt.bin.bits[2*i+1 -: 2]}
                                                : rd.wgt.i8[i];
    end
  endgenerate

  assign vec.valid = valid_q;
  // last read's data shows up in the end cycle
  assign vec.last  = valid_q && re_fm_end;
  assign vec.mode  = mode_q;
  // idle lanes forced to zero
  assign vec.wvec  = valid_q ? wunpack : '0;
  assign vec.avec  = valid_q ? rd.act : '0;

  // sequencer must close the read window after end
  a_window_closed: assert property (@(posedge clk) disable iff (reset)
    re_fm_end |=> !rd.en);

endmodule

// File: design/mac_stage.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module mac_stage
  import cnn_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  vec_if.sink   vec,
  output acc_t  result,
  output logic  result_valid
);

  // 9-bit signed weight times 8-bit activation
  localparam int PROD_W = 17;
  // room for the full lane sum
  localparam int SUM_W  = PROD_W + $clog2(`LANES);

  logic signed [PROD_W-1:0] prod_q [`LANES];
  logic                     v1_q;
  logic                     l1_q;
  logic                     first_q;
  acc_t                     acc_q;
  // heap-ordered tree with root at 0 and leaves from LANES-1 up
  logic signed [SUM_W-1:0]  node [2*`LANES-1];

  //////////////////////////////////////////////////////////////////////
  // stage 1 lane products

  genvar i;
  generate
    for (i = 0; i < `LANES; i = i + 1)
    begin : g_mul
      logic signed [8:0] wext;

      // bin2 weights count as unsigned 0..3
      assign wext = (vec.mode == MODE_BIN2) ? $signed({1'b0, vec.wvec[i]})
                                            : $signed({vec.wvec[i][7], vec.wvec[i]});

      always_ff @(posedge clk)
      begin
        prod_q[i] <= wext * $signed(vec.avec[i]);
      end

      assign node[`LANES-1+i] = prod_q[i];
    end
  endgenerate

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      v1_q <= 1'b0;
      l1_q <= 1'b0;
    end
    else
    begin
      v1_q <= vec.valid;
      l1_q <= vec.last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2 adder tree and accumulate

  genvar k;
  generate
    for (k = 0; k < `LANES-1; k = k + 1)
    begin : g_add
      assign node[k] = node[2*k+1] + node[2*k+2];
    end
  endgenerate

  // restart on the first vector after a last
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      first_q      <= 1'b1;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= v1_q && l1_q;
      if (v1_q)
      begin
        first_q <= l1_q;
      end
    end
  end

  // signed sum, the tree root sign extends into the accumulator
  always_ff @(posedge clk)
  begin
    if (v1_q)
    begin
      acc_q <= (first_q ? acc_t'(0) : acc_q) + node[0];
    end
  end

  // only good in the result_valid cycle until the next tile overwrites it
  assign result = acc_q;

endmodule

// File: design/conv_tile_top.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module conv_tile_top
  import cnn_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`AXI_ADR_BITS-1:0] awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`AXI_ADR_BITS-1:0] araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready
);

  // host write lanes
  logic                     we_wgt;
  logic                     we_act;
  logic [`BUF_ADR_BITS-1:0] wadr;
  logic [`WLANE_BITS-1:0]   lane;
  logic [31:0]              wbus;
  // run control
  logic                     start;
  wmode_e                   mode;
  logic [`BUF_ADR_BITS:0]   tile_len;
  logic                     busy;
  logic                     re_fm_en;
  logic                     re_fm_end;
  acc_t                     result;
  logic                     result_valid;

  buf_rd_if rd_bus ();
  vec_if    vec_bus ();

  axil_tile_ctrl u_ctrl (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .we_wgt, .we_act, .wadr, .lane, .wbus,
    .start, .mode, .tile_len, .busy, .result, .result_valid
  );

  tile_buffer u_buf (
    .clk, .we_wgt, .we_act, .wadr, .lane, .wbus, .rd(rd_bus)
  );

  tile_sequencer u_seq (
    .clk, .reset, .start, .tile_len, .result_valid, .re_fm_en, .re_fm_end, .busy
  );

  cv_weights_handler u_wh (
    .clk, .reset, .mode, .re_fm_en, .re_fm_end, .rd(rd_bus), .vec(vec_bus)
  );

  mac_stage u_mac (
    .clk, .reset, .vec(vec_bus), .result, .result_valid
  );

endmodule

// File: tests/tb_conv_tile.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module tb_conv_tile;

  // words loaded and tile cycles over all tests
  localparam int LOAD_WORDS  = 4 + 7 + 64;
  localparam int TILE_SUM    = 4 + 7 + 1 + 64 + 3 + 20;
  // one axi write or read with slack
  localparam int OP_CYC      = 8;
  localparam int CYCLE_LIMIT = 2 * ((LOAD_WORDS * 32 + 64) * OP_CYC + 3 * TILE_SUM);

  logic                     clk = 1'b0;
  logic                     reset;
  logic [`AXI_ADR_BITS-1:0] awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [31:0]              wdata;
  logic [3:0]               wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [`AXI_ADR_BITS-1:0] araddr;
  logic                     arvalid;
  logic                     arready;
  logic [31:0]              rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  // host copy of both buffers
  logic [`WORD_BITS-1:0] wgt_ref [`BUF_DEPTH];
  logic [`WORD_BITS-1:0] act_ref [`BUF_DEPTH];
  logic [31:0]           lfsr_q;
  int                    checks;
  int                    errors;
  int                    cycles;

  conv_tile_top uut (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  // taps 32 22 2 1 with one step per bit
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int b = 0; b < 32; b++)
    begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      w[b]   = lfsr_q[0];
    end
    return w;
  endfunction

  // drives on posedge and samples on negedge
  task automatic axil_write(input logic [13:0] addr, input logic [31:0] data, input int hold);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_val("wready", wready, 1);
    // handshake edge
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_val("bresp", bresp, 0);
    // response must wait for bready
    repeat (hold)
    begin
      @(negedge clk);
      check_val("bvalid", bvalid, 1);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [13:0] addr, input int hold, output logic [31:0] data);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    check_val("rresp", rresp, 0);
    // data held stable with rready low
    repeat (hold)
    begin
      @(negedge clk);
      check_val("rvalid", rvalid, 1);
      check_val("rdata", rdata, data);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // random word pairs at addresses 0..n-1 written lane by lane
  task automatic load_words(input int n);
    logic [31:0] w;
    for (int a = 0; a < n; a++)
    begin
      for (int l = 0; l < 16; l++)
      begin
        w = rand_word();
        wgt_ref[a][32*l +: 32] = w;
        axil_write(14'(`WGT_BASE + a*64 + l*4), w, 0);
        w = rand_word();
        act_ref[a][32*l +: 32] = w;
        axil_write(14'(`ACT_BASE + a*64 + l*4), w, 0);
      end
    end
  endtask

  // mode 0 takes signed bytes and mode 1 the low 128 bits as pairs 0..3
  function automatic logic [31:0] ref_sum(input logic m, input int len);
    int sum;
    int w;
    int x;
    sum = 0;
    for (int a = 0; a < len; a++)
    begin
      for (int l = 0; l < `LANES; l++)
      begin
        if (m)
          w = wgt_ref[a][2*l +: 2];
        else
          w = $signed(wgt_ref[a][8*l +: 8]);
        x = $signed(act_ref[a][8*l +: 8]);
        sum += w * x;
      end
    end
    return sum;
  endfunction

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[0]) axil_read(`REG_STATUS, 0, st);
  endtask

  task automatic run_tile(input logic m, input int len);
    logic [31:0] got;
    axil_write(`REG_CFG, {9'b0, len[6:0], 15'b0, m}, 0);
    axil_write(`REG_CTRL, 32'h1, 0);
    wait_done();
    axil_read(`REG_RESULT, 0, got);
    check_val("result", got, ref_sum(m, len));
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic status_and_cfg();
    logic [31:0] got;
    @(negedge clk);
    check_val("awready", awready, 0);
    check_val("wready", wready, 0);
    check_val("bvalid", bvalid, 0);
    check_val("arready", arready, 0);
    check_val("rvalid", rvalid, 0);
    @(posedge clk);
    axil_read(`REG_STATUS, 0, got);
    check_val("status", got, 0);
    axil_write(`REG_CFG, 32'h0025_0001, 0);
    axil_read(`REG_CFG, 0, got);
    check_val("cfg", got, 32'h0025_0001);
  endtask

  task automatic start_while_busy();
    logic [31:0] st;
    logic [31:0] got;
    axil_write(`REG_CFG, {9'b0, 7'd20, 15'b0, 1'b0}, 0);
    axil_write(`REG_CTRL, 32'h1, 0);
    axil_read(`REG_STATUS, 0, st);
    check_val("status.busy", st[1], 1);
    // a shorter tile would change the sum if the restart got through
    axil_write(`REG_CFG, {9'b0, 7'd5, 15'b0, 1'b0}, 0);
    axil_write(`REG_CTRL, 32'h1, 0);
    wait_done();
    axil_read(`REG_RESULT, 0, got);
    check_val("result", got, ref_sum(1'b0, 20));
    axil_read(`REG_STATUS, 0, st);
    check_val("status", st, 32'h1);
  endtask

  task automatic held_responses();
    logic [31:0] got;
    axil_write(`REG_CFG, 32'h0013_0000, 5);
    axil_read(`REG_CFG, 6, got);
    check_val("cfg", got, 32'h0013_0000);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr_q  = 32'hda7e_13aa;
    checks  = 0;
    errors  = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    status_and_cfg();
    load_words(4);
    run_tile(1'b0, 4);
    // upper bytes random while only the low 128 bits count
    load_words(7);
    run_tile(1'b1, 7);
    // address counter back to 0 for each tile
    load_words(64);
    run_tile(1'b0, 1);
    run_tile(1'b0, 64);
    run_tile(1'b0, 3);
    start_while_busy();
    held_responses();

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // run limit from tile lengths and axi traffic
  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/cnn_pkg.sv
design/tile_stage_if.sv
design/axil_tile_ctrl.sv
design/tile_buffer.sv
design/tile_sequencer.sv
design/cv_weights_handler.sv
design/mac_stage.sv
design/conv_tile_top.sv
tests/tb_conv_tile.sv

// File: run_sim.sh
#!/bin/sh
# build and run the conv tile testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_conv_tile
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_conv_tile)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
  exit 0
fi
exit 1
